//--- bench/rob_assert.sv
// protocol assertions for the reorder buffer, bound into every rob_top instance
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_assert (
	input logic               clk,
	input logic               rst,
	input logic               dispatch_en_i,
	input logic               stall_dp_o,
	input rob_pkg::rob_ptr_t  tail_idx_o,
	input rob_pkg::rob_ptr_t  br_idx_i,
	input logic               br_right_o,
	input logic               br_recovery_rdy_o,
	input logic               retire_rdy_o,
	input rob_pkg::prf_tag_t  fl_tag_o,
	input rob_pkg::prf_tag_t  arch_tag_o,
	input rob_pkg::log_dest_t arch_log_dest_o
);

	//----------------------------------------------------------------------
	// retire port
	//----------------------------------------------------------------------
	idle_retire_zero: assert property (@(posedge clk) disable iff (rst)
		!retire_rdy_o |-> (fl_tag_o == '0 && arch_tag_o == '0 && arch_log_dest_o == '0))
		else $error("retire outputs not zero without a retire");

	// a full buffer only opens up through a retire or a rollback
	stall_release: assert property (@(posedge clk) disable iff (rst)
		$fell(stall_dp_o) |-> (retire_rdy_o || $past(retire_rdy_o || br_recovery_rdy_o)))
		else $error("stall dropped with no slot freed");

	// tail moves by one per accepted dispatch
	dispatch_advance: assert property (@(posedge clk) disable iff (rst)
		(dispatch_en_i && !stall_dp_o && !br_recovery_rdy_o) |=>
		tail_idx_o == $past(tail_idx_o) + `ROB_PTR_W'(1))
		else $error("tail did not advance after dispatch");

	//----------------------------------------------------------------------
	// recovery
	//----------------------------------------------------------------------
	single_pulse: assert property (@(posedge clk) disable iff (rst)
		br_recovery_rdy_o |=> !br_recovery_rdy_o)
		else $error("recovery pulse longer than one cycle");

	rollback_tail: assert property (@(posedge clk) disable iff (rst)
		br_recovery_rdy_o |=> tail_idx_o == $past(br_idx_i) + `ROB_PTR_W'(1))
		else $error("tail not rolled back behind the branch");

	// younger entries survive a correct prediction
	right_keeps_tail: assert property (@(posedge clk) disable iff (rst)
		(br_right_o && !dispatch_en_i) |=> tail_idx_o == $past(tail_idx_o))
		else $error("tail moved on a correct prediction");

endmodule

bind rob_top rob_assert rob_assert_i (.*);

//--- bench/rob_tb.sv
// testbench for the reorder buffer; drives rob_top and checks retirement, stall and recovery
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_tb;

	localparam int WATCHDOG_CYCLES = 2000;	// six tests, each well under 300 cycles

	logic clk = 1'b0;
	logic rst;
	logic dispatch_en_i, br_flag_i, br_pretaken_i, halt_i, fu_done_i, fu_br_taken_i;
	logic br_done_i, br_taken_i, stall_dp_o, br_right_o, br_recovery_rdy_o;
	logic retire_rdy_o, halt_o;
	rob_pkg::prf_tag_t dest_tag_i, old_tag_i, fl_tag_o, arch_tag_o;
	rob_pkg::log_dest_t log_dest_i, fl_head_i, arch_log_dest_o, recover_fl_head_o;
	rob_pkg::pc_t pc_i, br_target_i, br_res_target_i, npc_o;
	rob_pkg::br_mask_t br_mask_i, br_recovery_mask_o;
	rob_pkg::rob_ptr_t fu_idx_i, br_idx_i, rd_idx_i, tail_idx_o;

	// reference model, one element per entry between head and tail
	rob_pkg::prf_tag_t q_dest[$];
	rob_pkg::prf_tag_t q_old[$];
	rob_pkg::log_dest_t q_ld[$];
	rob_pkg::rob_ptr_t q_idx[$];
	rob_pkg::pc_t pc_ref[`ROB_DEPTH];	// pc of the last entry written per slot
	int errors = 0;
	int tests = 0;

	rob_top rob_top_i (.*);

	always #50 clk = ~clk;

	task check_equal(input string sig, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp) else begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
			errors++;
		end
	endtask

	// inputs change 5 ns after the rising edge and strobes drop unless set again
	task step_cycle;
		@(posedge clk);
		#5;
		dispatch_en_i = 1'b0;
		fu_done_i = 1'b0;
		br_done_i = 1'b0;
	endtask

	task dispatch(input logic br, input logic pt, input rob_pkg::pc_t tgt, input logic hlt);
		step_cycle();
		check_equal("stall_dp_o", 64'(stall_dp_o), 64'd0);
		dispatch_en_i = 1'b1;
		dest_tag_i = rob_pkg::prf_tag_t'($urandom);
		old_tag_i = rob_pkg::prf_tag_t'($urandom);
		log_dest_i = rob_pkg::log_dest_t'($urandom);
		fl_head_i = rob_pkg::log_dest_t'($urandom);
		pc_i = {$urandom, $urandom};
		br_flag_i = br;
		br_pretaken_i = pt;
		br_target_i = tgt;
		br_mask_i = rob_pkg::br_mask_t'($urandom);
		halt_i = hlt;
		q_dest.push_back(dest_tag_i);
		q_old.push_back(old_tag_i);
		q_ld.push_back(log_dest_i);
		q_idx.push_back(tail_idx_o);
		pc_ref[tail_idx_o[`ROB_IDX_W-1:0]] = pc_i;
	endtask

	task complete(input rob_pkg::rob_ptr_t idx);
		step_cycle();
		fu_done_i = 1'b1;
		fu_idx_i = idx;
		fu_br_taken_i = 1'b0;
	endtask

	// complete everything outstanding, optionally out of order, and wait until empty
	task drain(input bit shuffle);
		rob_pkg::rob_ptr_t pend[$];
		rob_pkg::rob_ptr_t tmp;
		int j;
		step_cycle();
		pend = q_idx;
		if (shuffle) begin
			for (int k = pend.size() - 1; k > 0; k--) begin
				j = $urandom % (k + 1);
				tmp = pend[k];
				pend[k] = pend[j];
				pend[j] = tmp;
			end
		end
		foreach (pend[i])
			complete(pend[i]);
		step_cycle();
		while (q_idx.size() != 0)
			@(posedge clk);
	endtask

	task finish_test(input string name, input int err_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "mismatches");
	endtask

	// retire port against the reference queue
	always @(negedge clk) begin
		if (!rst && retire_rdy_o) begin
			if (q_idx.size() == 0) begin
				$display("retire at %0t ns with no entry outstanding", $time);
				errors++;
			end else begin
				check_equal("fl_tag_o", 64'(fl_tag_o), 64'(q_old.pop_front()));
				check_equal("arch_tag_o", 64'(arch_tag_o), 64'(q_dest.pop_front()));
				check_equal("arch_log_dest_o", 64'(arch_log_dest_o), 64'(q_ld.pop_front()));
				void'(q_idx.pop_front());
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("watchdog expired, the tests did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int e;
		rob_pkg::rob_ptr_t bidx;
		rob_pkg::rob_ptr_t exp_tail;
		rob_pkg::pc_t tgt;
		rob_pkg::br_mask_t exp_mask;
		rob_pkg::log_dest_t exp_fl;
		int k;
		void'($urandom(32'h58c8));
		{dispatch_en_i, br_flag_i, br_pretaken_i, halt_i, fu_done_i, fu_br_taken_i} = '0;
		{br_done_i, br_taken_i, dest_tag_i, old_tag_i, log_dest_i, fl_head_i} = '0;
		{pc_i, br_target_i, br_res_target_i, br_mask_i, fu_idx_i, br_idx_i, rd_idx_i} = '0;
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;

		//----------------------------------------------------------------------
		// reset state
		//----------------------------------------------------------------------
		e = errors;
		@(negedge clk);
		check_equal("stall_dp_o", 64'(stall_dp_o), 64'd0);
		check_equal("retire_rdy_o", 64'(retire_rdy_o), 64'd0);
		check_equal("br_recovery_rdy_o", 64'(br_recovery_rdy_o), 64'd0);
		check_equal("br_right_o", 64'(br_right_o), 64'd0);
		check_equal("halt_o", 64'(halt_o), 64'd0);
		check_equal("tail_idx_o", 64'(tail_idx_o), 64'd0);
		finish_test("reset", e);

		e = errors;
		repeat (10) dispatch(1'b0, 1'b0, 64'd0, 1'b0);
		drain(1'b1);
		finish_test("in-order retire", e);

		// fill, then free the head slot
		e = errors;
		repeat (32) dispatch(1'b0, 1'b0, 64'd0, 1'b0);
		step_cycle();
		@(negedge clk);
		check_equal("stall_dp_o", 64'(stall_dp_o), 64'd1);
		complete(q_idx[0]);
		@(negedge clk);
		while (!retire_rdy_o)
			@(negedge clk);
		check_equal("stall_dp_o", 64'(stall_dp_o), 64'd0);
		drain(1'b0);
		finish_test("full stall", e);

		e = errors;
		tgt = {$urandom, $urandom};
		dispatch(1'b1, 1'b1, tgt, 1'b0);
		bidx = q_idx[$];
		dispatch(1'b0, 1'b0, 64'd0, 1'b0);	// younger entry behind the branch
		step_cycle();
		br_done_i = 1'b1;
		br_idx_i = bidx;
		br_taken_i = 1'b1;
		br_res_target_i = tgt;
		@(negedge clk);
		check_equal("br_right_o", 64'(br_right_o), 64'd1);
		check_equal("br_recovery_rdy_o", 64'(br_recovery_rdy_o), 64'd0);
		drain(1'b0);
		finish_test("correct prediction", e);

		//----------------------------------------------------------------------
		// mispredict with three younger entries to squash
		//----------------------------------------------------------------------
		e = errors;
		dispatch(1'b1, 1'b0, tgt, 1'b0);
		bidx = q_idx[$];
		exp_mask = br_mask_i;
		exp_fl = fl_head_i;
		repeat (3) dispatch(1'b0, 1'b0, 64'd0, 1'b0);
		step_cycle();
		br_done_i = 1'b1;
		br_idx_i = bidx;
		br_taken_i = 1'b1;
		br_res_target_i = tgt;
		@(negedge clk);
		check_equal("br_recovery_rdy_o", 64'(br_recovery_rdy_o), 64'd1);
		check_equal("br_recovery_mask_o", 64'(br_recovery_mask_o), 64'(exp_mask));
		check_equal("recover_fl_head_o", 64'(recover_fl_head_o), 64'(exp_fl));
		@(negedge clk);	// resolution still held
		exp_tail = bidx + 1'b1;
		check_equal("br_recovery_rdy_o", 64'(br_recovery_rdy_o), 64'd0);
		check_equal("tail_idx_o", 64'(tail_idx_o), 64'(exp_tail));
		repeat (3) begin
			void'(q_dest.pop_back());
			void'(q_old.pop_back());
			void'(q_ld.pop_back());
			void'(q_idx.pop_back());
		end
		drain(1'b0);
		finish_test("mispredict recovery", e);

		e = errors;
		for (k = 0; k < 4; k++)
			dispatch(1'b0, 1'b0, 64'd0, k == 2);
		k = $urandom % 4;
		step_cycle();
		rd_idx_i = q_idx[k];
		@(negedge clk);
		check_equal("npc_o", npc_o, pc_ref[q_idx[k][`ROB_IDX_W-1:0]] + `PC_STEP);
		check_equal("halt_o", 64'(halt_o), 64'd0);
		complete(q_idx[0]);
		complete(q_idx[1]);
		step_cycle();
		while (q_idx.size() != 2)
			@(posedge clk);
		@(negedge clk);
		check_equal("halt_o", 64'(halt_o), 64'd1);
		drain(1'b0);
		finish_test("next pc and halt", e);

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- logic/rob_branch_check.sv
// per-entry pc and prediction storage with mispredict check and next-pc read
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_branch_check (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dispatch_en_i,
	input  rob_pkg::rob_ptr_t     tail_ptr_i,
	input  rob_pkg::pc_t          pc_i,
	input  logic                  br_flag_i,
	input  logic                  br_pretaken_i,
	input  rob_pkg::pc_t          br_target_i,
	input  rob_pkg::br_mask_t     br_mask_i,
	input  logic                  br_done_i,
	input  rob_pkg::rob_ptr_t     br_idx_i,
	input  logic                  br_taken_i,
	input  rob_pkg::pc_t          br_res_target_i,
	input  rob_pkg::rob_ptr_t     rd_idx_i,
	output rob_pkg::br_outcome_e  br_outcome_o,
	output rob_pkg::br_mask_t     br_recovery_mask_o,
	output rob_pkg::pc_t          npc_o
);

	rob_pkg::pc_t       pc_r [`ROB_DEPTH];
	rob_pkg::pc_t       target_r [`ROB_DEPTH];	// predicted target
	rob_pkg::br_mask_t  mask_r [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] br_flag_r;
	logic [`ROB_DEPTH-1:0] pretaken_r;

	rob_pkg::rob_idx_t tail_idx;
	rob_pkg::rob_idx_t chk_idx;
	logic mismatch;

	assign tail_idx = tail_ptr_i[`ROB_IDX_W-1:0];
	assign chk_idx = br_idx_i[`ROB_IDX_W-1:0];

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	// per-entry branch flag that gates the resolution check
	always_ff @(posedge clk) begin
		if (rst)
			br_flag_r <= '0;
		else if (dispatch_en_i)
			br_flag_r[tail_idx] <= br_flag_i;
	end

	always_ff @(posedge clk) begin
		if (dispatch_en_i) begin
			pc_r[tail_idx] <= pc_i;
			target_r[tail_idx] <= br_target_i;
			mask_r[tail_idx] <= br_mask_i;
			pretaken_r[tail_idx] <= br_pretaken_i;
		end
	end

	//----------------------------------------------------------------------
	// resolution check
	//----------------------------------------------------------------------
	// wrong direction or wrong target both count as a mispredict
	assign mismatch = (pretaken_r[chk_idx] != br_taken_i) |
		(target_r[chk_idx] != br_res_target_i);

	always_comb begin
		br_outcome_o = rob_pkg::BR_NONE;
		if (br_done_i && br_flag_r[chk_idx]) begin
			if (mismatch)
				br_outcome_o = rob_pkg::BR_WRONG;
			else
				br_outcome_o = rob_pkg::BR_RIGHT;
		end
	end

	assign br_recovery_mask_o = mask_r[chk_idx];	// mask to squash on recovery

	// fall-through pc for the branch unit
	assign npc_o = pc_r[rd_idx_i[`ROB_IDX_W-1:0]] + `PC_W'(`PC_STEP);

endmodule

//--- logic/rob_ctrl.sv
// head and tail pointer control for the reorder buffer, instantiated once in rob_top
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_en_i,
	input  logic                   head_done_i,
	input  logic                   head_halt_i,
	input  rob_pkg::br_outcome_e   br_outcome_i,
	input  rob_pkg::rob_ptr_t      br_idx_i,
	output rob_pkg::rob_ptr_t      head_ptr_o,
	output rob_pkg::rob_ptr_t      tail_ptr_o,
	output logic                   retire_rdy_o,
	output logic                   stall_dp_o,
	output logic                   halt_o,
	output logic                   br_right_o,
	output logic                   br_recovery_rdy_o
);

	rob_pkg::rob_ptr_t head_r;
	rob_pkg::rob_ptr_t tail_r;
	rob_pkg::rob_ptr_t head_nxt;
	rob_pkg::rob_ptr_t tail_nxt;

	logic empty;
	logic full;
	logic dp_accept;
	logic recovery_mark_r;	// low only in the cycle after a recovery pulse

	//----------------------------------------------------------------------
	// occupancy
	//----------------------------------------------------------------------
	assign empty = (head_r == tail_r);
	// same index, different wrap bit
	assign full = (head_r ^ tail_r) == {1'b1, {`ROB_IDX_W{1'b0}}};

	assign retire_rdy_o = head_done_i & ~empty;
	assign stall_dp_o = full & ~retire_rdy_o;	// a retiring head frees a slot this cycle
	assign halt_o = head_halt_i & ~empty;

	assign dp_accept = dispatch_en_i & ~stall_dp_o;

	//----------------------------------------------------------------------
	// branch resolution
	//----------------------------------------------------------------------
	assign br_right_o = (br_outcome_i == rob_pkg::BR_RIGHT);
	assign br_recovery_rdy_o = (br_outcome_i == rob_pkg::BR_WRONG) & recovery_mark_r;

	//----------------------------------------------------------------------
	// pointer update
	//----------------------------------------------------------------------
	always_comb begin
		head_nxt = head_r;
		if (retire_rdy_o)
			head_nxt = head_r + 1'b1;
	end

	// recovery rollback takes priority and drops a same-cycle dispatch
	always_comb begin
		if (br_recovery_rdy_o)
			tail_nxt = br_idx_i + 1'b1;	// first slot after the branch
		else if (dp_accept)
			tail_nxt = tail_r + 1'b1;
		else
			tail_nxt = tail_r;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			head_r <= head_nxt;
			tail_r <= tail_nxt;
		end
	end

	// one pulse per mispredict even if the resolution is held
	always_ff @(posedge clk) begin
		if (rst)
			recovery_mark_r <= 1'b1;
		else
			recovery_mark_r <= ~br_recovery_rdy_o;
	end

	assign head_ptr_o = head_r;
	assign tail_ptr_o = tail_r;

endmodule

//--- logic/rob_params.svh
// sizing constants for the reorder buffer, included by the package, the RTL and the bench
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

//----------------------------------------------------------------------
// buffer geometry
//----------------------------------------------------------------------
`define ROB_DEPTH	32	// entries
`define ROB_IDX_W	5	// entry index
`define ROB_PTR_W	6	// index plus wrap bit

//----------------------------------------------------------------------
// rename and branch field widths
//----------------------------------------------------------------------
`define PRF_TAG_W	6
`define LOG_DEST_W	5	// also the free-list head width
`define BR_MASK_W	4

`define PC_W		64
`define PC_STEP		4	// fixed instruction size

// empty tag and destination fields read back as this
`define TAG_RESET	31

`endif

//--- logic/rob_pkg.sv
// shared types for the reorder buffer, referenced with rob_pkg:: scoped names
`include "rob_params.svh"

package rob_pkg;

	//----------------------------------------------------------------------
	// pointers and indices
	//----------------------------------------------------------------------
	typedef logic [`ROB_PTR_W-1:0] rob_ptr_t;	// msb is the wrap bit
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	//----------------------------------------------------------------------
	// entry payload
	//----------------------------------------------------------------------
	typedef logic [`PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [`LOG_DEST_W-1:0] log_dest_t;	// free-list head uses it too
	typedef logic [`BR_MASK_W-1:0] br_mask_t;
	typedef logic [`PC_W-1:0] pc_t;

	// result of checking one branch against its resolution
	typedef enum logic [1:0] {
		BR_NONE  = 2'd0,	// no check, or not a branch
		BR_RIGHT = 2'd1,
		BR_WRONG = 2'd2
	} br_outcome_e;

endpackage

//--- logic/rob_rename_store.sv
// per-entry rename fields of the reorder buffer with retire and recovery read ports
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_rename_store (
	input  logic                clk,
	input  logic                rst,
	input  logic                dispatch_en_i,
	input  rob_pkg::rob_ptr_t   tail_ptr_i,
	input  rob_pkg::rob_ptr_t   head_ptr_i,
	input  logic                retire_rdy_i,
	input  rob_pkg::prf_tag_t   dest_tag_i,
	input  rob_pkg::prf_tag_t   old_tag_i,
	input  rob_pkg::log_dest_t  log_dest_i,
	input  rob_pkg::log_dest_t  fl_head_i,
	input  rob_pkg::rob_ptr_t   br_idx_i,
	output rob_pkg::prf_tag_t   fl_tag_o,
	output rob_pkg::prf_tag_t   arch_tag_o,
	output rob_pkg::log_dest_t  arch_log_dest_o,
	output rob_pkg::log_dest_t  recover_fl_head_o
);

	rob_pkg::prf_tag_t  dest_tag_r [`ROB_DEPTH];
	rob_pkg::prf_tag_t  old_tag_r [`ROB_DEPTH];
	rob_pkg::log_dest_t log_dest_r [`ROB_DEPTH];
	rob_pkg::log_dest_t fl_head_r [`ROB_DEPTH];	// free-list head at dispatch time

	rob_pkg::rob_idx_t tail_idx;
	rob_pkg::rob_idx_t head_idx;

	assign tail_idx = tail_ptr_i[`ROB_IDX_W-1:0];
	assign head_idx = head_ptr_i[`ROB_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				dest_tag_r[i] <= `PRF_TAG_W'(`TAG_RESET);
				old_tag_r[i] <= `PRF_TAG_W'(`TAG_RESET);
				log_dest_r[i] <= `LOG_DEST_W'(`TAG_RESET);
				fl_head_r[i] <= `LOG_DEST_W'(`TAG_RESET);
			end
		end else begin
			if (retire_rdy_i) begin
				dest_tag_r[head_idx] <= `PRF_TAG_W'(`TAG_RESET);
				old_tag_r[head_idx] <= `PRF_TAG_W'(`TAG_RESET);
				log_dest_r[head_idx] <= `LOG_DEST_W'(`TAG_RESET);
				fl_head_r[head_idx] <= `LOG_DEST_W'(`TAG_RESET);
			end
			// full buffer retiring and dispatching hits one slot, new entry wins
			if (dispatch_en_i) begin
				dest_tag_r[tail_idx] <= dest_tag_i;
				old_tag_r[tail_idx] <= old_tag_i;
				log_dest_r[tail_idx] <= log_dest_i;
				fl_head_r[tail_idx] <= fl_head_i;
			end
		end
	end

	//----------------------------------------------------------------------
	// read ports
	//----------------------------------------------------------------------
	assign fl_tag_o = retire_rdy_i ? old_tag_r[head_idx] : '0;	// old tag back to free list
	assign arch_tag_o = retire_rdy_i ? dest_tag_r[head_idx] : '0;
	assign arch_log_dest_o = retire_rdy_i ? log_dest_r[head_idx] : '0;

	assign recover_fl_head_o = fl_head_r[br_idx_i[`ROB_IDX_W-1:0]];

endmodule

//--- logic/rob_status.sv
// per-entry done, taken and halt bits of the reorder buffer
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_status (
	input  logic               clk,
	input  logic               rst,
	input  logic               dispatch_en_i,
	input  rob_pkg::rob_ptr_t  tail_ptr_i,
	input  rob_pkg::rob_ptr_t  head_ptr_i,
	input  logic               retire_en_i,
	input  logic               fu_done_i,
	input  rob_pkg::rob_ptr_t  fu_idx_i,
	input  logic               fu_br_taken_i,
	input  logic               halt_i,
	output logic               head_done_o,
	output logic               head_halt_o
);

	logic [`ROB_DEPTH-1:0] done_r;
	logic [`ROB_DEPTH-1:0] taken_r;	// resolved branch direction
	logic [`ROB_DEPTH-1:0] halt_r;

	rob_pkg::rob_idx_t tail_idx;
	rob_pkg::rob_idx_t head_idx;
	rob_pkg::rob_idx_t fu_idx;

	assign tail_idx = tail_ptr_i[`ROB_IDX_W-1:0];
	assign head_idx = head_ptr_i[`ROB_IDX_W-1:0];
	assign fu_idx = fu_idx_i[`ROB_IDX_W-1:0];

	// later writes in this block take priority on a shared slot
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
			taken_r <= '0;
			halt_r <= '0;
		end else begin
			if (retire_en_i) begin
				done_r[head_idx] <= 1'b0;
				halt_r[head_idx] <= 1'b0;
			end
			if (dispatch_en_i) begin
				done_r[tail_idx] <= 1'b0;
				taken_r[tail_idx] <= 1'b0;
				halt_r[tail_idx] <= halt_i;
			end
			if (fu_done_i) begin	// completion wins over dispatch
				done_r[fu_idx] <= 1'b1;
				taken_r[fu_idx] <= fu_br_taken_i;
			end
		end
	end

	assign head_done_o = done_r[head_idx];
	assign head_halt_o = halt_r[head_idx];

endmodule

//--- logic/rob_top.sv
// reorder buffer top level, the DUT seen by the bench
`timescale 1ns/10ps

module rob_top (
	input  logic                  clk,
	input  logic                  rst,

	//----------------------------------------------------------------------
	// dispatch
	//----------------------------------------------------------------------
	input  logic                  dispatch_en_i,
	input  rob_pkg::prf_tag_t     dest_tag_i,	// new tag from free list
	input  rob_pkg::prf_tag_t     old_tag_i,	// previous mapping
	input  rob_pkg::log_dest_t    log_dest_i,
	input  rob_pkg::log_dest_t    fl_head_i,
	input  rob_pkg::pc_t          pc_i,
	input  logic                  br_flag_i,
	input  logic                  br_pretaken_i,
	input  rob_pkg::pc_t          br_target_i,
	input  rob_pkg::br_mask_t     br_mask_i,
	input  logic                  halt_i,
	output rob_pkg::rob_ptr_t     tail_idx_o,
	output logic                  stall_dp_o,

	// completion
	input  logic                  fu_done_i,
	input  rob_pkg::rob_ptr_t     fu_idx_i,
	input  logic                  fu_br_taken_i,

	//----------------------------------------------------------------------
	// branch resolution and recovery
	//----------------------------------------------------------------------
	input  logic                  br_done_i,
	input  rob_pkg::rob_ptr_t     br_idx_i,
	input  logic                  br_taken_i,
	input  rob_pkg::pc_t          br_res_target_i,
	output logic                  br_right_o,
	output logic                  br_recovery_rdy_o,
	output rob_pkg::br_mask_t     br_recovery_mask_o,
	output rob_pkg::log_dest_t    recover_fl_head_o,

	input  rob_pkg::rob_ptr_t     rd_idx_i,
	output rob_pkg::pc_t          npc_o,

	// retirement
	output logic                  retire_rdy_o,
	output rob_pkg::prf_tag_t     fl_tag_o,
	output rob_pkg::prf_tag_t     arch_tag_o,
	output rob_pkg::log_dest_t    arch_log_dest_o,
	output logic                  halt_o
);

	rob_pkg::rob_ptr_t     head_ptr;
	rob_pkg::rob_ptr_t     tail_ptr;
	rob_pkg::br_outcome_e  br_outcome;
	logic head_done;
	logic head_halt;
	logic dp_accept;	// dispatch seen by the stores

	assign dp_accept = dispatch_en_i & ~stall_dp_o;
	assign tail_idx_o = tail_ptr;

	rob_ctrl rob_ctrl_i (
		.clk(clk), .rst(rst),
		.dispatch_en_i(dispatch_en_i),
		.head_done_i(head_done), .head_halt_i(head_halt),
		.br_outcome_i(br_outcome), .br_idx_i(br_idx_i),
		.head_ptr_o(head_ptr), .tail_ptr_o(tail_ptr),
		.retire_rdy_o(retire_rdy_o), .stall_dp_o(stall_dp_o), .halt_o(halt_o),
		.br_right_o(br_right_o), .br_recovery_rdy_o(br_recovery_rdy_o)
	);

	rob_rename_store rob_rename_store_i (
		.clk(clk), .rst(rst),
		.dispatch_en_i(dp_accept), .tail_ptr_i(tail_ptr), .head_ptr_i(head_ptr),
		.retire_rdy_i(retire_rdy_o),
		.dest_tag_i(dest_tag_i), .old_tag_i(old_tag_i),
		.log_dest_i(log_dest_i), .fl_head_i(fl_head_i), .br_idx_i(br_idx_i),
		.fl_tag_o(fl_tag_o), .arch_tag_o(arch_tag_o),
		.arch_log_dest_o(arch_log_dest_o), .recover_fl_head_o(recover_fl_head_o)
	);

	rob_branch_check rob_branch_check_i (
		.clk(clk), .rst(rst),
		.dispatch_en_i(dp_accept), .tail_ptr_i(tail_ptr),
		.pc_i(pc_i), .br_flag_i(br_flag_i), .br_pretaken_i(br_pretaken_i),
		.br_target_i(br_target_i), .br_mask_i(br_mask_i),
		.br_done_i(br_done_i), .br_idx_i(br_idx_i), .br_taken_i(br_taken_i),
		.br_res_target_i(br_res_target_i), .rd_idx_i(rd_idx_i),
		.br_outcome_o(br_outcome), .br_recovery_mask_o(br_recovery_mask_o),
		.npc_o(npc_o)
	);

	rob_status rob_status_i (
		.clk(clk), .rst(rst),
		.dispatch_en_i(dp_accept), .tail_ptr_i(tail_ptr), .head_ptr_i(head_ptr),
		.retire_en_i(retire_rdy_o),
		.fu_done_i(fu_done_i), .fu_idx_i(fu_idx_i), .fu_br_taken_i(fu_br_taken_i),
		.halt_i(halt_i),
		.head_done_o(head_done), .head_halt_o(head_halt)
	);

endmodule

//--- run.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
verilator --binary --timing --assert --top-module rob_tb -f sources.f -o rob_sim \
	&& ./obj_dir/rob_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

//--- sources.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_ctrl.sv
logic/rob_rename_store.sv
logic/rob_branch_check.sv
logic/rob_status.sv
logic/rob_top.sv
bench/rob_assert.sv
bench/rob_tb.sv
